// ==== source/usb_pins_pkg.sv ====
// Packed types for the USB chip pins and the pull-up enables
package usb_pins_pkg;

  // Pin inputs seen by the always-on domain
  // The data lines and the VBUS sense arrive straight from the pads with no synchronization
  typedef struct packed {
    // D+ line level
    logic dp;
    // D- line level
    logic dn;
    // VBUS sense, high while the host supplies power
    logic sense;
  } usb_pins_t;

  // Pull-up enables for the two data lines
  // The enabled pull-up selects the speed, and with pin flipping it may sit on D-
  typedef struct packed {
    // D+ pull-up enable
    logic dp_en;
    // D- pull-up enable
    logic dn_en;
  } usb_pullup_t;

endpackage

// ==== source/aon_wake_pkg.sv ====
// Wake detector state enum and the wake event struct
package aon_wake_pkg;

  // Takeover state of the always-on detector
  // In WAKE_IDLE the USB core owns the pull-ups and nothing is recorded
  // In WAKE_ACTIVE the detector holds the pull-ups and watches the bus
  typedef enum logic [0:0] {
    WAKE_IDLE   = 1'b0,
    WAKE_ACTIVE = 1'b1
  } wake_state_e;

  // One level per kind of wake event
  // The same layout carries both the filtered events and the sticky latched copies
  typedef struct packed {
    // Bus left the idle level set by the held pull-ups (resume or reset)
    logic bus_not_idle;
    // Both data lines low, which is how the host signals a bus reset
    logic bus_reset;
    // VBUS sense went low, so the cable was pulled or the host dropped power
    logic sense_lost;
  } wake_events_t;

  // The three fields are reported together on the top-level events output
  // Bit order from MSB: bus_not_idle, bus_reset, sense_lost
  // A zero value means nothing has been seen since the last takeover
  // The controller ORs new events into the latched copy while active
  // Leaving the active state returns the latched copy to zero

endpackage

// ==== source/aon_signal_filter.sv ====
// Two-flop synchronizer followed by a stability filter of configurable length
`timescale 1ns/100ps

module aon_signal_filter #(
  // Number of consecutive equal samples needed before the output follows
  parameter int unsigned Cycles = 4
) (
  input  logic clk_aon_i,
  input  logic rst_aon_ni,
  input  logic filter_i,
  output logic filter_o
);

  // Counter only needs to reach Cycles-1 and keeps at least one bit
  localparam int unsigned CntWidth = (Cycles > 1) ? $clog2(Cycles) : 1;
  localparam logic [CntWidth-1:0] CntMax = CntWidth'(Cycles - 1);

  // Synchronizer stages for the raw input, which is asynchronous to the always-on clock
  logic sync_q1, sync_q2;
  // Candidate value and the number of samples it has been seen in a row
  logic stored_q;
  logic [CntWidth-1:0] cnt_q;
  // Candidate changed on this sample
  logic update_stored;
  // Candidate has been equal for Cycles samples
  logic stable;
  logic filter_q;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= filter_i;
      sync_q2 <= sync_q1;
    end
  end

  assign update_stored = (sync_q2 != stored_q);
  assign stable        = !update_stored && (cnt_q == CntMax);

  // The sample that brings a new candidate counts as its first one
  // Each further equal sample counts up until the count saturates
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      stored_q <= 1'b0;
      cnt_q    <= '0;
    end else if (update_stored) begin
      stored_q <= sync_q2;
      cnt_q    <= CntWidth'(1);
    end else if (cnt_q != CntMax) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Output keeps its last value until the candidate has settled
  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      filter_q <= 1'b0;
    end else if (stable) begin
      filter_q <= stored_q;
    end
  end

  assign filter_o = filter_q;

endmodule

// ==== source/usb_line_monitor.sv ====
// USB line monitor deriving not-idle, SE0 and sense-lost conditions and filtering each one
`timescale 1ns/100ps

module usb_line_monitor import usb_pins_pkg::*; import aon_wake_pkg::*; #(
  // Stability length for the not-idle condition
  parameter int unsigned NotIdleCycles = 4,
  // Stability length for the SE0 and sense-lost conditions
  parameter int unsigned SeCycles = 3
) (
  input  logic         clk_aon_i,
  input  logic         rst_aon_ni,
  // Raw pad levels
  input  usb_pins_t    pins_i,
  // Pull-up enables currently driven to the pads
  input  usb_pullup_t  pad_pullup_i,
  // Filtered conditions, one level per field
  output wake_events_t events_o
);

  // Unfiltered conditions, still asynchronous
  logic not_idle_raw;
  logic se0_raw;
  logic sense_lost_raw;

  // During suspend the enabled pull-up alone sets the line levels
  // Any line that disagrees with its pull-up means the host is driving the bus
  // This catches a resume K state as well as SE0
  // Comparing against the pull-ups rather than fixed levels keeps pin flipping working
  assign not_idle_raw = (pins_i.dp != pad_pullup_i.dp_en) |
                        (pins_i.dn != pad_pullup_i.dn_en);

  // Both lines low is single-ended zero, the bus reset signal
  assign se0_raw = ~pins_i.dp & ~pins_i.dn;

  // VBUS sense low means the device is no longer powered by the host
  assign sense_lost_raw = ~pins_i.sense;

  // Longer filter on activity so short noise does not wake the chip
  // It also gives a core that stayed on time to see the resume first
  aon_signal_filter #(
    .Cycles (NotIdleCycles)
  ) u_filter_not_idle (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (not_idle_raw),
    .filter_o   (events_o.bus_not_idle)
  );

  // SE0 filter
  aon_signal_filter #(
    .Cycles (SeCycles)
  ) u_filter_se0 (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (se0_raw),
    .filter_o   (events_o.bus_reset)
  );

  // Sense filter uses the same length as SE0
  aon_signal_filter #(
    .Cycles (SeCycles)
  ) u_filter_sense (
    .clk_aon_i  (clk_aon_i),
    .rst_aon_ni (rst_aon_ni),
    .filter_i   (sense_lost_raw),
    .filter_o   (events_o.sense_lost)
  );

endmodule

// ==== source/aon_wake_ctrl.sv ====
// Takeover state machine, sticky event latches and wake request of the always-on detector
`timescale 1ns/100ps

module aon_wake_ctrl import aon_wake_pkg::*; (
  input  logic         clk_aon_i,
  input  logic         rst_aon_ni,
  // Filtered conditions from the line monitor
  input  wake_events_t events_i,
  // Core hands control over, sampled in WAKE_IDLE only
  input  logic         suspend_req_i,
  // Core takes control back, sampled in WAKE_ACTIVE only
  input  logic         wake_ack_i,
  // High while this block holds the pull-ups
  output logic         active_o,
  // Events latched since the takeover
  output wake_events_t events_o,
  // Request to power the core back up
  output logic         wake_req_o
);

  wake_state_e state_q, state_d;
  logic active;

  wake_events_t events_q, events_d;
  logic wake_req_q, wake_req_d;
  // Any filtered condition present on this cycle
  logic any_event;

  // Two states only, request in and acknowledge out
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      WAKE_IDLE: begin
        // Core is still in charge, wait for it to ask for suspend
        if (suspend_req_i) begin
          state_d = WAKE_ACTIVE;
        end
      end
      WAKE_ACTIVE: begin
        // Stay in charge until the core has woken and says so
        if (wake_ack_i) begin
          state_d = WAKE_IDLE;
        end
      end
      default: begin
        state_d = WAKE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      state_q <= WAKE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign active    = (state_q == WAKE_ACTIVE);
  assign any_event = |events_i;

  // Each event sticks once seen while active
  // Dropping out of the active state clears everything on the next edge
  assign events_d   = active ? wake_events_t'(events_q | events_i) : '0;
  assign wake_req_d = active & (any_event | wake_req_q);

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      events_q   <= '0;
      wake_req_q <= 1'b0;
    end else begin
      events_q   <= events_d;
      wake_req_q <= wake_req_d;
    end
  end

  assign active_o   = active;
  assign events_o   = events_q;
  assign wake_req_o = wake_req_q;

endmodule

// ==== source/pullup_hold.sv ====
// Pull-up enable synchronizer, takeover hold register and pad enable mux
`timescale 1ns/100ps

module pullup_hold import usb_pins_pkg::*; (
  input  logic        clk_aon_i,
  input  logic        rst_aon_ni,
  // Enables from the USB core, in the core clock domain
  input  usb_pullup_t core_pullup_i,
  // High while the always-on detector owns the pull-ups
  input  logic        active_i,
  // Enables driven to the pads
  output usb_pullup_t pad_pullup_o
);

  // Core enables brought into the always-on domain
  usb_pullup_t sync_q1, sync_q2;
  // Value kept on the pads during takeover
  usb_pullup_t hold_q, hold_d;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= core_pullup_i;
      sync_q2 <= sync_q1;
    end
  end

  // Follow the core while it is in charge, freeze once active
  // The core keeps its enables steady before requesting suspend,
  // so the frozen value matches what was on the pads at takeover
  assign hold_d = active_i ? hold_q : sync_q2;

  always_ff @(posedge clk_aon_i or negedge rst_aon_ni) begin
    if (!rst_aon_ni) begin
      hold_q <= '0;
    end else begin
      hold_q <= hold_d;
    end
  end

  // When idle the core drives the pads directly with no added latency
  // When active the core may be powered down and its outputs are meaningless
  assign pad_pullup_o = active_i ? hold_q : core_pullup_i;

endmodule

// ==== source/usb_aon_wake_top.sv ====
// Top level of the always-on USB wake detector connecting monitor, controller and pull-up hold
`timescale 1ns/100ps

module usb_aon_wake_top import usb_pins_pkg::*; import aon_wake_pkg::*; #(
  // Filter length for bus activity
  parameter int unsigned NotIdleCycles = 4,
  // Filter length for SE0 and VBUS sense
  parameter int unsigned SeCycles = 3
) (
  input  logic         clk_aon_i,
  input  logic         rst_aon_ni,
  // Chip pins
  input  usb_pins_t    pins_i,
  // Pull-up enables from the USB core
  input  usb_pullup_t  core_pullup_i,
  // Level handshake with the core, already in the always-on domain
  input  logic         suspend_req_i,
  input  logic         wake_ack_i,
  // Pull-up enables to the pads
  output usb_pullup_t  pad_pullup_o,
  // Power-up request to the core
  output logic         wake_req_o,
  // Events recorded during takeover
  output wake_events_t events_o,
  // Debug view of the takeover state
  output logic         wake_active_o
);

  // Filtered conditions on their way to the controller
  wake_events_t filt_events;
  // Takeover state shared by the controller and the pull-up hold
  logic wake_active;

  // Input side, compares the pins with the pull-ups actually on the pads
  usb_line_monitor #(
    .NotIdleCycles (NotIdleCycles),
    .SeCycles      (SeCycles)
  ) u_line_monitor (
    .clk_aon_i    (clk_aon_i),
    .rst_aon_ni   (rst_aon_ni),
    .pins_i       (pins_i),
    .pad_pullup_i (pad_pullup_o),
    .events_o     (filt_events)
  );

  // Takeover FSM and event latches
  aon_wake_ctrl u_wake_ctrl (
    .clk_aon_i     (clk_aon_i),
    .rst_aon_ni    (rst_aon_ni),
    .events_i      (filt_events),
    .suspend_req_i (suspend_req_i),
    .wake_ack_i    (wake_ack_i),
    .active_o      (wake_active),
    .events_o      (events_o),
    .wake_req_o    (wake_req_o)
  );

  // Output side, keeps the pull-ups steady while the core sleeps
  pullup_hold u_pullup_hold (
    .clk_aon_i     (clk_aon_i),
    .rst_aon_ni    (rst_aon_ni),
    .core_pullup_i (core_pullup_i),
    .active_i      (wake_active),
    .pad_pullup_o  (pad_pullup_o)
  );

  assign wake_active_o = wake_active;

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and power-on reset generator
`timescale 1ns/100ps

module tb_clock_gen #(
  // Clock period in ns
  parameter int unsigned PeriodNs = 20,
  // Rising edges seen while reset is held low
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset goes high on a falling edge, away from the edge the flops sample on
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== verification/usb_aon_wake_tb.sv ====
// Table-driven testbench for the always-on USB wake detector with typed compare tasks
`timescale 1ns/100ps

module usb_aon_wake_tb import usb_pins_pkg::*; import aon_wake_pkg::*; ();

  // Same value as the DUT default for the SE0 and sense filters
  localparam int unsigned SeCycles = 3;
  // Longest wait for any DUT response, in clock cycles
  localparam int unsigned WaitLimit = 40;
  // Idle cycles on J before each row so every filter and the hold register settle
  localparam int unsigned SettleCycles = 12;
  // Cycles on J after a glitch before the outputs are checked
  localparam int unsigned QuietCycles = 10;

  // Bus levels used by the stimulus
  // With the D+ pull-up enabled J is the idle state
  localparam usb_pins_t PinsJ      = '{dp: 1'b1, dn: 1'b0, sense: 1'b1};
  localparam usb_pins_t PinsK      = '{dp: 1'b0, dn: 1'b1, sense: 1'b1};
  localparam usb_pins_t PinsSe0    = '{dp: 1'b0, dn: 1'b0, sense: 1'b1};
  localparam usb_pins_t PinsNoVbus = '{dp: 1'b1, dn: 1'b0, sense: 1'b0};
  localparam usb_pullup_t PullDp   = '{dp_en: 1'b1, dn_en: 1'b0};

  localparam wake_events_t EvNone     = '0;
  localparam wake_events_t EvNotIdle  = '{bus_not_idle: 1'b1, bus_reset: 1'b0, sense_lost: 1'b0};
  localparam wake_events_t EvReset    = '{bus_not_idle: 1'b1, bus_reset: 1'b1, sense_lost: 1'b0};
  localparam wake_events_t EvSense    = '{bus_not_idle: 1'b0, bus_reset: 1'b0, sense_lost: 1'b1};

  // Selectors for the wait task
  localparam int SelReq    = 0;
  localparam int SelActive = 1;
  localparam int SelClear  = 2;

  // One stimulus row
  // A hold of zero asks for a random glitch length
  typedef struct packed {
    usb_pins_t    pins;
    int unsigned  hold;
    logic         suspend;
    wake_events_t exp_events;
    logic         exp_req;
  } stim_row_t;

  localparam int NumRows = 9;

  logic         clk_aon;
  logic         rst_aon_n;
  usb_pins_t    pins;
  usb_pullup_t  core_pullup;
  logic         suspend_req;
  logic         wake_ack;
  usb_pullup_t  pad_pullup;
  logic         wake_req;
  wake_events_t events;
  logic         wake_active;
  stim_row_t    rows [NumRows];
  int           seed;

  tb_clock_gen #(
    .PeriodNs    (20),
    .ResetCycles (5)
  ) u_clock_gen (
    .clk_o  (clk_aon),
    .rst_no (rst_aon_n)
  );

  usb_aon_wake_top DUT (
    .clk_aon_i     (clk_aon),
    .rst_aon_ni    (rst_aon_n),
    .pins_i        (pins),
    .core_pullup_i (core_pullup),
    .suspend_req_i (suspend_req),
    .wake_ack_i    (wake_ack),
    .pad_pullup_o  (pad_pullup),
    .wake_req_o    (wake_req),
    .events_o      (events),
    .wake_active_o (wake_active)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_events(input string name, input wake_events_t got, input wake_events_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pullup(input string name, input usb_pullup_t got, input usb_pullup_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Current level of the selected DUT response
  function automatic logic observe(input int sel);
    case (sel)
      SelReq:    return wake_req;
      SelActive: return wake_active;
      default:   return (events == EvNone) && !wake_req;
    endcase
  endfunction

  // Polls on falling edges until the response reaches the level or the limit runs out
  task automatic wait_for(input int sel, input logic level, input string what);
    int unsigned n;
    n = 0;
    while (observe(sel) !== level) begin
      if (n == WaitLimit) begin
        abort_run($sformatf("timeout: %s never happened within %0d cycles", what, WaitLimit));
      end
      @(negedge clk_aon);
      n++;
    end
  endtask

  task automatic hold_cycles(input int unsigned n);
    repeat (n) @(negedge clk_aon);
  endtask

  // Core in charge and bus idle on J with the D+ pull-up
  task automatic settle_idle();
    @(negedge clk_aon);
    pins        = PinsJ;
    core_pullup = PullDp;
    suspend_req = 1'b0;
    wake_ack    = 1'b0;
    hold_cycles(SettleCycles);
  endtask

  // Suspend request level held until the takeover shows up
  task automatic enter_active();
    suspend_req = 1'b1;
    wait_for(SelActive, 1'b1, "wake_active_o rising after the suspend request");
    suspend_req = 1'b0;
    check_pullup("pad_pullup_o", pad_pullup, PullDp);
  endtask

  // Acknowledge hands control back and everything must then read zero
  task automatic leave_active();
    wake_ack = 1'b1;
    wait_for(SelActive, 1'b0, "wake_active_o falling after the acknowledge");
    wake_ack = 1'b0;
    wait_for(SelClear, 1'b1, "events_o and wake_req_o clearing after the acknowledge");
    check_bit("wake_active_o", wake_active, 1'b0);
  endtask

  function automatic stim_row_t make_row(input usb_pins_t p, input int unsigned hold,
                                         input logic susp, input wake_events_t ev,
                                         input logic req);
    stim_row_t r;
    r.pins       = p;
    r.hold       = hold;
    r.suspend    = susp;
    r.exp_events = ev;
    r.exp_req    = req;
    return r;
  endfunction

  // Wake rows come first, followed by short glitches while active and long events while idle
  task automatic fill_table();
    rows[0] = make_row(PinsK,      12, 1'b1, EvNotIdle, 1'b1);
    rows[1] = make_row(PinsSe0,    12, 1'b1, EvReset,   1'b1);
    rows[2] = make_row(PinsNoVbus, 12, 1'b1, EvSense,   1'b1);
    rows[3] = make_row(PinsK,      0,  1'b1, EvNone,    1'b0);
    rows[4] = make_row(PinsSe0,    0,  1'b1, EvNone,    1'b0);
    rows[5] = make_row(PinsNoVbus, 0,  1'b1, EvNone,    1'b0);
    rows[6] = make_row(PinsK,      12, 1'b0, EvNone,    1'b0);
    rows[7] = make_row(PinsSe0,    12, 1'b0, EvNone,    1'b0);
    rows[8] = make_row(PinsNoVbus, 12, 1'b0, EvNone,    1'b0);
  endtask

  task automatic apply_row(input stim_row_t row);
    int unsigned len;
    settle_idle();
    if (row.suspend) begin
      enter_active();
    end
    // Glitches stay shorter than the shortest filter
    if (row.hold == 0) begin
      len = 1 + ($unsigned($random(seed)) % (SeCycles - 1));
    end else begin
      len = row.hold;
    end
    pins = row.pins;
    if (row.exp_req) begin
      wait_for(SelReq, 1'b1, "wake_req_o rising after the bus event");
    end
    // Keeps the event up long enough for the slower not-idle filter as well
    hold_cycles(len);
    if (!row.exp_req) begin
      pins = PinsJ;
      hold_cycles(QuietCycles);
    end
    check_events("events_o", events, row.exp_events);
    check_bit("wake_req_o", wake_req, row.exp_req);
    check_bit("wake_active_o", wake_active, row.suspend);
    pins = PinsJ;
    if (row.suspend) begin
      leave_active();
    end
  endtask

  initial begin
    int unsigned n;
    seed        = 32'h3fa207f3;
    pins        = PinsJ;
    core_pullup = PullDp;
    suspend_req = 1'b0;
    wake_ack    = 1'b0;
    fill_table();

    n = 0;
    while (!rst_aon_n) begin
      if (n == WaitLimit) begin
        abort_run("timeout: reset was never released");
      end
      @(negedge clk_aon);
      n++;
    end
    @(negedge clk_aon);

    // Everything low after reset, and the pads follow the core at once while idle
    check_bit("wake_req_o", wake_req, 1'b0);
    check_events("events_o", events, EvNone);
    check_bit("wake_active_o", wake_active, 1'b0);
    for (int v = 0; v < 4; v++) begin
      @(negedge clk_aon);
      core_pullup = usb_pullup_t'(v[1:0]);
      #1;
      check_pullup("pad_pullup_o", pad_pullup, usb_pullup_t'(v[1:0]));
    end

    // Takeover freezes the pads at the value captured before it
    settle_idle();
    enter_active();
    for (int v = 0; v < 4; v++) begin
      core_pullup = usb_pullup_t'(v[1:0]);
      hold_cycles(3);
      check_pullup("pad_pullup_o", pad_pullup, PullDp);
    end
    core_pullup = PullDp;
    leave_active();

    for (int i = 0; i < NumRows; i++) begin
      apply_row(rows[i]);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
source/usb_pins_pkg.sv
source/aon_wake_pkg.sv
source/aon_signal_filter.sv
source/usb_line_monitor.sv
source/aon_wake_ctrl.sv
source/pullup_hold.sv
source/usb_aon_wake_top.sv
verification/tb_clock_gen.sv
verification/usb_aon_wake_tb.sv

// ==== Makefile ====
# Verilator build and run of the always-on USB wake detector testbench

TOP := usb_aon_wake_tb
SRCS := $(wildcard source/*.sv verification/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): flist.f $(SRCS)
	verilator --binary -j 0 --top-module $(TOP) -f flist.f

# Passes only if the pass line shows up in the simulator output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
